// ==== bench/acq_bench.sv ====
`timescale 1ns/1ns
`include "acq_macros.svh"

module acq_bench;

  localparam int NUM_CYC = 6000;  // random cycles after reset
  localparam int CLK_NS  = 20;
  localparam int MARGIN  = 200;   // watchdog slack in cycles

  //////////////////////////////////////////////////
  // dut signals
  //////////////////////////////////////////////////

  logic                   adc_clk;
  logic                   top_rst;
  acq_data_pkg::adc_raw_t adc_dat_i [`ACQ_MNA];
  logic                   ext_trg_i;
  logic [`ACQ_MNA-1:0]    irq_clr_i;
  logic [`ACQ_MNA-1:0]    ctl_str_i;
  logic [`ACQ_MNA-1:0]    ctl_stp_i;
  logic [`ACQ_MNA-1:0]    ctl_trg_i;
  acq_data_pkg::smp_t     cfg_lvl_i [`ACQ_MNA];
  logic [`ACQ_MNA-1:0]    cfg_neg_i;
  acq_ctl_pkg::trg_src_t  cfg_src_i [`ACQ_MNA];
  acq_ctl_pkg::len_t      cfg_len_i [`ACQ_MNA];
  acq_data_pkg::smp_t     smp_dat_o [`ACQ_MNA];
  logic [`ACQ_MNA-1:0]    smp_vld_o;
  logic [`ACQ_MNA-1:0]    smp_lst_o;
  logic [`ACQ_MNA-1:0]    trg_o;
  logic [`ACQ_MNA-1:0]    irq_o;

  bench_clk #(.PERIOD_NS(CLK_NS), .RST_CYC(8)) bench_clk_i (
    .clk_o (adc_clk),
    .rst_o (top_rst)
  );

  acq_top acq_top_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .ext_trg_i (ext_trg_i),
    .irq_clr_i (irq_clr_i),
    .ctl_str_i (ctl_str_i),
    .ctl_stp_i (ctl_stp_i),
    .ctl_trg_i (ctl_trg_i),
    .cfg_lvl_i (cfg_lvl_i),
    .cfg_neg_i (cfg_neg_i),
    .cfg_src_i (cfg_src_i),
    .cfg_len_i (cfg_len_i),
    .smp_dat_o (smp_dat_o),
    .smp_vld_o (smp_vld_o),
    .smp_lst_o (smp_lst_o),
    .trg_o     (trg_o),
    .irq_o     (irq_o)
  );

  //////////////////////////////////////////////////
  // random source
  //////////////////////////////////////////////////

  logic [15:0] lfsr = 16'd93;  // seed

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);  // galois taps 16 14 13 11
  endfunction

  // one lfsr step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r    = {r[14:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  function automatic logic rand_bit();
    logic [15:0] r;
    r = rand_bits(1);
    return r[0];
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  acq_data_pkg::adc_raw_t  m_raw [`ACQ_MNA];  // front register
  acq_data_pkg::smp_t      m_prv [`ACQ_MNA];  // sample one cycle back
  acq_data_pkg::smp_t      m_dat [`ACQ_MNA];
  acq_ctl_pkg::osc_state_t m_st  [`ACQ_MNA];
  acq_ctl_pkg::len_t       m_rem [`ACQ_MNA];  // samples left after this one
  logic [`ACQ_MNA-1:0]     m_vld;
  logic [`ACQ_MNA-1:0]     m_lst;
  logic [`ACQ_MNA-1:0]     m_trg;
  logic [`ACQ_MNA-1:0]     m_irq;
  logic                    m_ext_dly;
  logic                    m_ext_evn;

  int n_err = 0;
  int n_chk = 0;
  int n_cap = 0;   // completed captures
  int n_stop = 0;  // aborted captures

  // sign bit kept and magnitude bits flipped
  function automatic acq_data_pkg::smp_t to_twos(input acq_data_pkg::adc_raw_t raw);
    return acq_data_pkg::smp_t'(raw ^ 16'h7FFF);
  endfunction

  task automatic reset_model();
    for (int i = 0; i < `ACQ_MNA; i++) begin
      m_raw[i] = '0;
      m_prv[i] = to_twos('0);  // dut history loads during reset too
      m_st[i]  = acq_ctl_pkg::IDLE;
      m_rem[i] = '0;
    end
    m_vld     = '0;
    m_lst     = '0;
    m_trg     = '0;
    m_irq     = '0;
    m_ext_dly = 1'b0;
    m_ext_evn = 1'b0;
  endtask

  // one clock edge with all reads taken before it
  task automatic step_model();
    acq_data_pkg::smp_t s [`ACQ_MNA];
    logic [`ACQ_MNA-1:0] xt;
    logic hit;
    logic fst;
    logic nxt;
    logic last;
    for (int i = 0; i < `ACQ_MNA; i++) begin
      s[i] = to_twos(m_raw[i]);
      if (cfg_src_i[i] == `TRG_SRC_EXT) xt[i] = m_ext_evn;
      else if (cfg_src_i[i] == `TRG_SRC_NBR) xt[i] = m_trg[(i + 1) % `ACQ_MNA];
      else xt[i] = 1'b0;
    end
    m_irq     = (m_irq & ~irq_clr_i) | m_lst;  // set beats clear
    m_ext_evn = ext_trg_i && !m_ext_dly;
    m_ext_dly = ext_trg_i;
    for (int i = 0; i < `ACQ_MNA; i++) begin
      case (cfg_src_i[i])
        `TRG_SRC_SW  : hit = ctl_trg_i[i];
        `TRG_SRC_LVL : hit = cfg_neg_i[i] ? (m_prv[i] >= cfg_lvl_i[i] && s[i] < cfg_lvl_i[i])
                                          : (m_prv[i] < cfg_lvl_i[i] && s[i] >= cfg_lvl_i[i]);
        default      : hit = xt[i];
      endcase
      fst  = 1'b0;
      nxt  = 1'b0;
      last = 1'b0;
      case (m_st[i])
        acq_ctl_pkg::IDLE : begin
          if (ctl_str_i[i]) m_st[i] = acq_ctl_pkg::ARMED;
        end
        acq_ctl_pkg::ARMED : begin
          if (ctl_stp_i[i]) begin
            m_st[i] = acq_ctl_pkg::IDLE;
            n_stop++;
          end else if (hit) begin
            fst      = 1'b1;
            m_rem[i] = cfg_len_i[i];
            last     = (m_rem[i] == '0);
            m_st[i]  = last ? acq_ctl_pkg::IDLE : acq_ctl_pkg::CAPT;
          end
        end
        default : begin  // capturing
          if (ctl_stp_i[i]) begin
            m_st[i] = acq_ctl_pkg::IDLE;
            n_stop++;
          end else begin
            nxt      = 1'b1;
            m_rem[i] = m_rem[i] - 1'b1;
            last     = (m_rem[i] == '0);
            if (last) m_st[i] = acq_ctl_pkg::IDLE;
          end
        end
      endcase
      if (last) n_cap++;
      m_vld[i] = fst || nxt;
      m_lst[i] = last;
      m_trg[i] = fst;
      if (fst || nxt) m_dat[i] = s[i];
      m_prv[i] = s[i];
      m_raw[i] = adc_dat_i[i];
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic drive_idle();
    for (int i = 0; i < `ACQ_MNA; i++) begin
      adc_dat_i[i] <= '0;
      cfg_lvl_i[i] <= '0;
      cfg_src_i[i] <= `TRG_SRC_SW;
      cfg_len_i[i] <= '0;
    end
    ext_trg_i <= 1'b0;
    irq_clr_i <= '0;
    ctl_str_i <= '0;
    ctl_stp_i <= '0;
    ctl_trg_i <= '0;
    cfg_neg_i <= '0;
  endtask

  // config only touched while the model says idle
  task automatic drive_random();
    logic [15:0] r;
    for (int i = 0; i < `ACQ_MNA; i++) begin
      adc_dat_i[i] <= rand_bits(16);
      if (m_st[i] == acq_ctl_pkg::IDLE) begin
        r = rand_bits(3);
        if (r[2:0] == 3'd0) begin
          r = rand_bits(2);
          cfg_src_i[i] <= r[1:0];
          cfg_neg_i[i] <= rand_bit();
          cfg_lvl_i[i] <= rand_bits(16);
          r = rand_bits(4);
          cfg_len_i[i] <= {12'd0, r[3:0]};  // 0 to 15
        end
      end
      r = rand_bits(2);
      ctl_str_i[i] <= (r[1:0] == 2'd0);  // also hits busy channels
      r = rand_bits(3);
      ctl_trg_i[i] <= (r[2:0] == 3'd0);
      r = rand_bits(5);
      ctl_stp_i[i] <= (r[4:0] == 5'd0);  // rare abort
      r = rand_bits(3);
      irq_clr_i[i] <= (r[2:0] == 3'd0);
    end
    if (rand_bit() && rand_bit()) ext_trg_i <= ~ext_trg_i;
  endtask

  always @(posedge adc_clk) begin
    if (top_rst) begin
      reset_model();
      drive_idle();
    end else begin
      step_model();
      drive_random();
    end
  end

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_smp(input string name, input acq_data_pkg::smp_t exp,
                           input acq_data_pkg::smp_t act);
    n_chk++;
    if (act !== exp) begin
      n_err++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    n_chk++;
    if (act !== exp) begin
      n_err++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_irq(input string name, input logic [`ACQ_MNA-1:0] exp,
                           input logic [`ACQ_MNA-1:0] act);
    n_chk++;
    if (act !== exp) begin
      n_err++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // outputs settled by the falling edge
  always @(negedge adc_clk) begin
    if (!top_rst) begin
      for (int i = 0; i < `ACQ_MNA; i++) begin
        check_flag($sformatf("ch%0d smp_vld at %0t", i, $time), m_vld[i], smp_vld_o[i]);
        check_flag($sformatf("ch%0d smp_lst at %0t", i, $time), m_lst[i], smp_lst_o[i]);
        check_flag($sformatf("ch%0d trg at %0t", i, $time), m_trg[i], trg_o[i]);
        if (m_vld[i]) begin
          check_smp($sformatf("ch%0d smp_dat at %0t", i, $time), m_dat[i], smp_dat_o[i]);
        end
      end
      check_irq($sformatf("irq at %0t", $time), m_irq, irq_o);
    end
  end

  //////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////

  initial begin
    drive_idle();
    @(negedge top_rst);
    repeat (NUM_CYC) @(posedge adc_clk);
    @(negedge adc_clk);
    #(CLK_NS / 4);  // last compare of this falling edge is done
    if (n_cap == 0 || n_stop == 0) begin
      n_err++;
      $display("no completed or no stopped capture seen during the run");
    end
    $display("errors: %0d in %0d checks, captures %0d, stops %0d",
             n_err, n_chk, n_cap, n_stop);
    if (n_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((NUM_CYC + 8 + MARGIN) * CLK_NS);
    $display("run did not finish in time, watchdog expired");
    $display("TEST FAILED");
    $finish;
  end

endmodule : acq_bench

// ==== bench/bench_clk.sv ====
`timescale 1ns/1ns

module bench_clk #(
  parameter int PERIOD_NS = 20,  // adc clock period
  parameter int RST_CYC   = 8    // reset length in cycles
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYC) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule : bench_clk

// ==== project.f ====
+incdir+rtl
rtl/acq_data_pkg.sv
rtl/acq_ctl_pkg.sv
rtl/adc_front.sv
rtl/osc_chan.sv
rtl/osc_event_hub.sv
rtl/acq_top.sv
bench/bench_clk.sv
bench/acq_bench.sv

// ==== rtl/acq_ctl_pkg.sv ====
`include "acq_macros.svh"

package acq_ctl_pkg;

  //////////////////////////////////////////////////
  // control and configuration types
  //////////////////////////////////////////////////

  // number of samples after the trigger sample
  typedef logic [`ACQ_LW-1:0] len_t;

  // trigger source select, codes TRG_SRC_*
  typedef logic [`TRG_SRC_W-1:0] trg_src_t;

  //////////////////////////////////////////////////
  // channel fsm
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE  = 2'd0,  // stopped
    ARMED = 2'd1,  // waiting for trigger
    CAPT  = 2'd2   // streaming samples out
  } osc_state_t;

endpackage : acq_ctl_pkg

// ==== rtl/acq_data_pkg.sv ====
`include "acq_macros.svh"

package acq_data_pkg;

  //////////////////////////////////////////////////
  // sample path types
  //////////////////////////////////////////////////

  // raw word as it comes off the adc pins
  // negative slope offset binary
  typedef logic [`ACQ_DW-1:0] adc_raw_t;

  // converted sample, two's complement
  typedef logic signed [`ACQ_DW-1:0] smp_t;

endpackage : acq_data_pkg

// ==== rtl/acq_macros.svh ====
`ifndef ACQ_MACROS_SVH
`define ACQ_MACROS_SVH

//////////////////////////////////////////////////
// channel count and widths
//////////////////////////////////////////////////

`define ACQ_MNA 2   // acquisition channels
`define ACQ_DW  16  // adc word and sample width
`define ACQ_LW  16  // capture length counter width

//////////////////////////////////////////////////
// trigger source codes
//////////////////////////////////////////////////

`define TRG_SRC_W   2     // selector width

`define TRG_SRC_SW  2'd0  // software strobe
`define TRG_SRC_LVL 2'd1  // level crossing
`define TRG_SRC_EXT 2'd2  // external pin, edge found in hub
// neighbour is channel (i+1) mod ACQ_MNA
`define TRG_SRC_NBR 2'd3

`endif

// ==== rtl/acq_top.sv ====
`timescale 1ns/1ns
`include "acq_macros.svh"

module acq_top (
  input  logic                   adc_clk,
  input  logic                   top_rst,
  // adc and external pins
  input  acq_data_pkg::adc_raw_t adc_dat_i [`ACQ_MNA],
  input  logic                   ext_trg_i,
  input  logic [`ACQ_MNA-1:0]    irq_clr_i,
  // per channel control strobes
  input  logic [`ACQ_MNA-1:0]    ctl_str_i,
  input  logic [`ACQ_MNA-1:0]    ctl_stp_i,
  input  logic [`ACQ_MNA-1:0]    ctl_trg_i,
  // per channel configuration
  input  acq_data_pkg::smp_t     cfg_lvl_i [`ACQ_MNA],
  input  logic [`ACQ_MNA-1:0]    cfg_neg_i,
  input  acq_ctl_pkg::trg_src_t  cfg_src_i [`ACQ_MNA],
  input  acq_ctl_pkg::len_t      cfg_len_i [`ACQ_MNA],
  // captured streams
  output acq_data_pkg::smp_t     smp_dat_o [`ACQ_MNA],
  output logic [`ACQ_MNA-1:0]    smp_vld_o,
  output logic [`ACQ_MNA-1:0]    smp_lst_o,
  output logic [`ACQ_MNA-1:0]    trg_o,
  // interrupts
  output logic [`ACQ_MNA-1:0]    irq_o
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  acq_data_pkg::smp_t  smp [`ACQ_MNA];  // converted samples
  logic [`ACQ_MNA-1:0] xtrg;            // hub to channels

  //////////////////////////////////////////////////
  // adc input stage
  //////////////////////////////////////////////////

  adc_front adc_front_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .smp_o     (smp)
  );

  //////////////////////////////////////////////////
  // oscilloscope channels
  //////////////////////////////////////////////////

  generate
    for (genvar i = 0; i < `ACQ_MNA; i++) begin : g_osc
      osc_chan osc_chan_i (
        .adc_clk   (adc_clk),
        .top_rst   (top_rst),
        .smp_i     (smp[i]),
        .ctl_str_i (ctl_str_i[i]),
        .ctl_stp_i (ctl_stp_i[i]),
        .ctl_trg_i (ctl_trg_i[i]),
        .cfg_lvl_i (cfg_lvl_i[i]),
        .cfg_neg_i (cfg_neg_i[i]),
        .cfg_src_i (cfg_src_i[i]),
        .cfg_len_i (cfg_len_i[i]),
        .xtrg_i    (xtrg[i]),
        .smp_dat_o (smp_dat_o[i]),
        .smp_vld_o (smp_vld_o[i]),
        .smp_lst_o (smp_lst_o[i]),  // also feeds the hub
        .trg_o     (trg_o[i])       // also feeds the hub
      );
    end : g_osc
  endgenerate

  //////////////////////////////////////////////////
  // event routing and interrupts
  //////////////////////////////////////////////////

  osc_event_hub osc_event_hub_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .ext_trg_i (ext_trg_i),
    .cfg_src_i (cfg_src_i),  // hub needs to know who listens to what
    .trg_i     (trg_o),
    .lst_i     (smp_lst_o),
    .irq_clr_i (irq_clr_i),
    .xtrg_o    (xtrg),
    .irq_o     (irq_o)
  );

endmodule : acq_top

// ==== rtl/adc_front.sv ====
`timescale 1ns/1ns
`include "acq_macros.svh"

module adc_front (
  input  logic                   adc_clk,
  input  logic                   top_rst,
  input  acq_data_pkg::adc_raw_t adc_dat_i [`ACQ_MNA],  // raw adc words
  output acq_data_pkg::smp_t     smp_o     [`ACQ_MNA]   // converted samples
);

  //////////////////////////////////////////////////
  // input registers
  //////////////////////////////////////////////////

  acq_data_pkg::adc_raw_t adc_raw [`ACQ_MNA];  // first flop after the pins

  generate
    for (genvar i = 0; i < `ACQ_MNA; i++) begin : g_adc
      // one register stage per channel
      always_ff @(posedge adc_clk, posedge top_rst) begin
        if (top_rst) begin
          adc_raw[i] <= '0;
        end else begin
          adc_raw[i] <= adc_dat_i[i];
        end
      end

      // negative slope offset binary to two's complement
      // keep sign bit, flip the rest
      assign smp_o[i] = acq_data_pkg::smp_t'({adc_raw[i][`ACQ_DW-1],
                                              ~adc_raw[i][`ACQ_DW-2:0]});
    end : g_adc
  endgenerate

endmodule : adc_front

// ==== rtl/osc_chan.sv ====
`timescale 1ns/1ns
`include "acq_macros.svh"

module osc_chan (
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // sample from adc_front
  input  acq_data_pkg::smp_t    smp_i,
  // control strobes
  input  logic                  ctl_str_i,  // start, arms the channel
  input  logic                  ctl_stp_i,  // stop, back to idle
  input  logic                  ctl_trg_i,  // software trigger
  // configuration, stable outside idle
  input  acq_data_pkg::smp_t    cfg_lvl_i,  // trigger level
  input  logic                  cfg_neg_i,  // 1 = falling crossing
  input  acq_ctl_pkg::trg_src_t cfg_src_i,  // trigger source
  input  acq_ctl_pkg::len_t     cfg_len_i,  // samples after trigger
  // routed trigger from hub
  input  logic                  xtrg_i,
  // captured stream
  output acq_data_pkg::smp_t    smp_dat_o,
  output logic                  smp_vld_o,
  output logic                  smp_lst_o,
  output logic                  trg_o       // trigger event
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  acq_ctl_pkg::osc_state_t state;
  acq_ctl_pkg::osc_state_t state_nxt;

  acq_data_pkg::smp_t smp_prv;  // sample of previous cycle
  acq_ctl_pkg::len_t  cnt;      // samples still to come

  logic lvl_rise;
  logic lvl_fall;
  logic lvl_hit;
  logic trg_hit;   // selected source fires
  logic cnt_end;   // last sample in CAPT
  logic cap_fst;   // trigger sample taken
  logic cap_nxt;   // follow-up sample taken
  logic cap_lst;   // sample is the final one

  //////////////////////////////////////////////////
  // trigger detection
  //////////////////////////////////////////////////

  // signed compare, prev below and now at or above
  assign lvl_rise = (smp_prv <  cfg_lvl_i) && (smp_i >= cfg_lvl_i);
  assign lvl_fall = (smp_prv >= cfg_lvl_i) && (smp_i <  cfg_lvl_i);  // mirror
  assign lvl_hit  = cfg_neg_i ? lvl_fall : lvl_rise;

  always_comb begin
    case (cfg_src_i)
      `TRG_SRC_SW  : trg_hit = ctl_trg_i;
      `TRG_SRC_LVL : trg_hit = lvl_hit;
      `TRG_SRC_EXT,
      `TRG_SRC_NBR : trg_hit = xtrg_i;  // hub already picked the right one
      default      : trg_hit = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // fsm
  //////////////////////////////////////////////////

  assign cnt_end = (cnt == acq_ctl_pkg::len_t'(1));

  // stop has priority over any capture in the same cycle
  assign cap_fst = (state == acq_ctl_pkg::ARMED) && !ctl_stp_i && trg_hit;
  assign cap_nxt = (state == acq_ctl_pkg::CAPT)  && !ctl_stp_i;
  assign cap_lst = (cap_fst && (cfg_len_i == '0)) || (cap_nxt && cnt_end);

  always_comb begin
    state_nxt = state;
    case (state)
      acq_ctl_pkg::IDLE : begin
        if (ctl_str_i) state_nxt = acq_ctl_pkg::ARMED;
      end
      acq_ctl_pkg::ARMED : begin
        if (ctl_stp_i) begin
          state_nxt = acq_ctl_pkg::IDLE;
        end else if (trg_hit) begin
          // zero length means the trigger sample is the only one
          state_nxt = cap_lst ? acq_ctl_pkg::IDLE : acq_ctl_pkg::CAPT;
        end
      end
      acq_ctl_pkg::CAPT : begin
        if (ctl_stp_i || cnt_end) state_nxt = acq_ctl_pkg::IDLE;
      end
      default : state_nxt = acq_ctl_pkg::IDLE;  // illegal code recovery
    endcase
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state     <= acq_ctl_pkg::IDLE;
      smp_vld_o <= 1'b0;
      smp_lst_o <= 1'b0;
      trg_o     <= 1'b0;
    end else begin
      state     <= state_nxt;
      smp_vld_o <= cap_fst || cap_nxt;
      smp_lst_o <= cap_lst;
      trg_o     <= cap_fst;  // lines up with first smp_vld_o
    end
  end

  //////////////////////////////////////////////////
  // sample path and counter
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    smp_prv <= smp_i;  // edge detector history, every cycle
    if (cap_fst || cap_nxt) begin
      smp_dat_o <= smp_i;
    end
    if (cap_fst) begin
      cnt <= cfg_len_i;  // load at trigger
    end else if (cap_nxt) begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule : osc_chan

// ==== rtl/osc_event_hub.sv ====
`timescale 1ns/1ns
`include "acq_macros.svh"

module osc_event_hub (
  input  logic                  adc_clk,
  input  logic                  top_rst,
  input  logic                  ext_trg_i,               // external trigger pin
  input  acq_ctl_pkg::trg_src_t cfg_src_i [`ACQ_MNA],    // per channel source
  input  logic  [`ACQ_MNA-1:0]  trg_i,                   // channel trigger events
  input  logic  [`ACQ_MNA-1:0]  lst_i,                   // channel last events
  input  logic  [`ACQ_MNA-1:0]  irq_clr_i,               // interrupt clear
  output logic  [`ACQ_MNA-1:0]  xtrg_o,                  // routed triggers
  output logic  [`ACQ_MNA-1:0]  irq_o                    // sticky interrupts
);

  //////////////////////////////////////////////////
  // external trigger edge
  //////////////////////////////////////////////////

  logic ext_dly;  // pin one cycle back
  logic ext_evn;  // registered rising edge

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      ext_dly <= 1'b0;
      ext_evn <= 1'b0;
    end else begin
      ext_dly <= ext_trg_i;
      ext_evn <= ext_trg_i && !ext_dly;  // one cycle pulse
    end
  end

  //////////////////////////////////////////////////
  // trigger routing
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `ACQ_MNA; i++) begin
      case (cfg_src_i[i])
        `TRG_SRC_EXT : xtrg_o[i] = ext_evn;
        `TRG_SRC_NBR : xtrg_o[i] = trg_i[(i+1) % `ACQ_MNA];  // wraps to channel 0
        default      : xtrg_o[i] = 1'b0;  // sw and level handled in channel
      endcase
    end
  end

  //////////////////////////////////////////////////
  // interrupts
  //////////////////////////////////////////////////

  // set on last event, clear by strobe, set wins
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      irq_o <= '0;
    end else begin
      irq_o <= (irq_o & ~irq_clr_i) | lst_i;
    end
  end

endmodule : osc_event_hub

// ==== run.sh ====
#!/bin/sh
# compile and run the acquisition testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module acq_bench \
  -f project.f

out=$(./obj_dir/Vacq_bench)
echo "$out"

if echo "$out" | grep -q "^TEST PASSED$"; then
  exit 0
else
  exit 1
fi
